/* Bender.yml */
package:
  name: link_test

sources:
  - include_dirs:
      - design
    files:
      - design/ccb_pkg.sv
      - design/boot_pkg.sv
      - design/ccb_rx.sv
      - design/lane_monitor.sv
      - design/boot_fsm.sv
      - design/link_test_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/link_test_asserts.sv
      - sim/tb_link_test.sv

/* design/boot_fsm.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module boot_fsm
    import ccb_pkg::*;
    import boot_pkg::*;
(
    input  logic      clk40,
    input  logic      PRBS_reset,
    input  ccb_dec_t  dec_i,
    input  logic      inject_i,
    input  lane_vec_t tx_done_i,
    input  lane_vec_t rx_done_i,
    input  lane_vec_t live_err_i,
    input  lane_vec_t latched_err_i,
    output lane_vec_t tx_reset_o,
    output lane_vec_t rx_reset_o,
    output logic      err_clear_o,
    output logic      inject_o,
    output led_t      led_o
);

    boot_phase_t            phase_q;
    boot_phase_t            phase_d;
    logic [`LT_TIMER_W-1:0] timer_q;
    logic                   timer_hold;
    logic                   rx_hold;
    logic                   in_inject;
    logic                   in_check;
    logic                   inject_d1;
    logic                   inject_d2;
    logic                   inject_edge;

    ////////////////////////////////////////
    // Phase timer
    ////////////////////////////////////////

    // Held at zero while waiting on done flags, in reset and in check
    assign timer_hold = (phase_q == RESET) || (phase_q == EN_TX_DONE) ||
                        (phase_q == EN_RX_DONE) || (phase_q == EN_PRBS_CK);

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            timer_q <= '0;
        end else if (timer_hold) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Boot sequence
    ////////////////////////////////////////

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            RESET: begin
                phase_d = EN_TX;
            end
            EN_TX: begin
                if (timer_q >= `LT_T_TX) begin
                    phase_d = EN_TX_DONE;
                end
            end
            // All transmitters out of reset before rx release
            EN_TX_DONE: begin
                if (&tx_done_i) begin
                    phase_d = EN_RX;
                end
            end
            EN_RX: begin
                if (timer_q >= `LT_T_RX) begin
                    phase_d = EN_RX_DONE;
                end
            end
            EN_RX_DONE: begin
                if (&rx_done_i) begin
                    phase_d = PRBS_INJECT;
                end
            end
            // Thresholds below are cumulative
            PRBS_INJECT: begin
                if (timer_q >= `LT_T_INJ) begin
                    phase_d = PRBS_INJECT_DONE;
                end
            end
            PRBS_INJECT_DONE: begin
                if (timer_q >= `LT_T_INJ_DONE) begin
                    phase_d = PRBS_INJECT_CLEAR;
                end
            end
            PRBS_INJECT_CLEAR: begin
                if (timer_q >= `LT_T_CLEAR) begin
                    phase_d = EN_PRBS_CK;
                end
            end
            EN_PRBS_CK: begin
                phase_d = EN_PRBS_CK;
            end
            default: begin
                phase_d = RESET;
            end
        endcase
        // Resync restarts the boot from any phase
        if (dec_i.resync) begin
            phase_d = RESET;
        end
    end

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            phase_q <= RESET;
        end else begin
            phase_q <= phase_d;
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign rx_hold   = (phase_q == RESET) || (phase_q == EN_TX) || (phase_q == EN_TX_DONE);
    assign in_inject = (phase_q == PRBS_INJECT) || (phase_q == PRBS_INJECT_DONE) ||
                       (phase_q == PRBS_INJECT_CLEAR);
    assign in_check  = (phase_q == EN_PRBS_CK);

    // Transceiver resets, tx released first
    assign tx_reset_o = {`LT_LANES{phase_q == RESET}};
    assign rx_reset_o = {`LT_LANES{rx_hold}};

    // Latch runs free only during injection and check
    always_comb begin
        case (phase_q)
            PRBS_INJECT: err_clear_o = 1'b0;
            EN_PRBS_CK:  err_clear_o = dec_i.bxreset;
            default:     err_clear_o = 1'b1;
        endcase
    end

    // Rising edge of the front-panel inject level
    assign inject_edge = inject_d1 && !inject_d2;

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            inject_d1 <= 1'b0;
            inject_d2 <= 1'b0;
            inject_o  <= 1'b0;
        end else begin
            inject_d1 <= inject_i;
            inject_d2 <= inject_d1;
            // force-error strobe, check phase only
            inject_o  <= in_check && (dec_i.bx0 || inject_edge);
        end
    end

    // Upper nibble phase code, lower nibble lanes 4 to 7
    always_comb begin
        led_o[7:4] = phase_code(phase_q);
        if (in_inject) begin
            led_o[3:0] = live_err_i[`LT_LANES-1:`LT_DISP_LO];
        end else if (in_check) begin
            led_o[3:0] = latched_err_i[`LT_LANES-1:`LT_DISP_LO];
        end else begin
            led_o[3:0] = 4'b0000;
        end
    end

endmodule

/* design/boot_pkg.sv */
`include "link_test_defines.svh"

package boot_pkg;

    // One bit per optical lane
    typedef logic [`LT_LANES-1:0] lane_vec_t;

    // Front-panel LED bank
    typedef logic [7:0] led_t;

    ////////////////////////////////////////
    // Boot sequencer phases
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        RESET             = 4'd0,
        EN_TX             = 4'd1,
        EN_TX_DONE        = 4'd2,
        EN_RX             = 4'd3,
        EN_RX_DONE        = 4'd4,
        PRBS_INJECT       = 4'd5,
        PRBS_INJECT_DONE  = 4'd6,
        PRBS_INJECT_CLEAR = 4'd7,
        EN_PRBS_CK        = 4'd8
    } boot_phase_t;

    // LED code for the upper nibble
    // Inject done shows 1000 and clear shows 0111, as on the panel legend
    function automatic logic [3:0] phase_code(input boot_phase_t phase);
        case (phase)
            RESET:             return 4'b0001;
            EN_TX:             return 4'b0010;
            EN_TX_DONE:        return 4'b0011;
            EN_RX:             return 4'b0100;
            EN_RX_DONE:        return 4'b0101;
            PRBS_INJECT:       return 4'b0110;
            PRBS_INJECT_DONE:  return 4'b1000;
            PRBS_INJECT_CLEAR: return 4'b0111;
            EN_PRBS_CK:        return 4'b1111;
            default:           return 4'b0000;
        endcase
    endfunction

endpackage

/* design/ccb_pkg.sv */
`include "link_test_defines.svh"

package ccb_pkg;

    ////////////////////////////////////////
    // CCB command types
    ////////////////////////////////////////

    // Six-bit command code from the CCB word
    typedef logic [`LT_CMD_W-1:0] ccb_cmd_t;

    // Decoded commands
    // Each field is a one-cycle pulse on clk40
    typedef struct packed {
        // Bunch crossing zero
        logic bx0;
        // Restart of the whole boot sequence
        logic resync;
        // Clears the latched lane errors
        logic bxreset;
    } ccb_dec_t;

endpackage

/* design/ccb_rx.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module ccb_rx
    import ccb_pkg::*;
(
    input  logic                 clk40,
    input  logic                 PRBS_reset,
    input  logic [`LT_CCB_W-1:0] ccb_i,
    output ccb_dec_t             dec_o
);

    // Raw bus as sampled at the pins
    logic [`LT_CCB_W-1:0] ccb_q;
    // Bus after inversion, active high
    logic [`LT_CCB_W-1:0] ccb_pos;
    ccb_cmd_t             cmd;
    logic                 strobe;

    ////////////////////////////////////////
    // Input register
    ////////////////////////////////////////

    // Idle CCB lines sit high on the backplane
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            ccb_q <= '1;
        end else begin
            ccb_q <= ccb_i;
        end
    end

    // Active low on the pins
    assign ccb_pos = ~ccb_q;

    // Command field and its strobe
    assign cmd    = ccb_pos[`LT_CMD_LSB +: `LT_CMD_W];
    assign strobe = ccb_pos[`LT_STROBE_BIT];

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////

    // Codes are distinct, so one word gives at most one pulse
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            dec_o <= '0;
        end else begin
            dec_o.bx0     <= strobe && (cmd == `LT_CMD_BX0);
            dec_o.resync  <= strobe && (cmd == `LT_CMD_RESYNC);
            dec_o.bxreset <= strobe && (cmd == `LT_CMD_BXRESET);
        end
    end

endmodule

/* design/lane_monitor.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module lane_monitor
    import boot_pkg::*;
(
    input  logic      clk40,
    input  logic      PRBS_reset,
    input  lane_vec_t prbs_err_i,
    input  logic      err_clear_i,
    output lane_vec_t live_err_o,
    output lane_vec_t latched_err_o
);

    // Single input register on the per-lane checker flags
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            live_err_o <= {`LT_LANES{1'b0}};
        end else begin
            live_err_o <= prbs_err_i;
        end
    end

    ////////////////////////////////////////
    // Sticky error latch
    ////////////////////////////////////////

    // Any registered error sets its lane until cleared
    // Clear takes priority over an error in the same cycle
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            latched_err_o <= {`LT_LANES{1'b0}};
        end else if (err_clear_i) begin
            latched_err_o <= {`LT_LANES{1'b0}};
        end else begin
            latched_err_o <= latched_err_o | live_err_o;
        end
    end

endmodule

/* design/link_test_defines.svh */
`ifndef LINK_TEST_DEFINES_SVH
`define LINK_TEST_DEFINES_SVH

// Lane count of the optical link board
`define LT_LANES        8
// First lane shown on the front-panel LEDs
`define LT_DISP_LO      4

// CCB backplane bus, active low on the pins
`define LT_CCB_W        51
// Command field position inside the inverted word
`define LT_CMD_LSB      2
`define LT_CMD_W        6
// Command strobe, qualifies the command field
`define LT_STROBE_BIT   10

// Command codes decoded on this board
`define LT_CMD_BX0      6'h01
`define LT_CMD_RESYNC   6'h03
`define LT_CMD_BXRESET  6'h32

// Boot timer thresholds in clk40 cycles
// Injection, settle and clear run on one count
`define LT_T_TX         20
`define LT_T_RX         40
`define LT_T_INJ        140
`define LT_T_INJ_DONE   160
`define LT_T_CLEAR      180
`define LT_TIMER_W      8

`endif

/* design/link_test_top.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module link_test_top
    import ccb_pkg::*;
    import boot_pkg::*;
(
    input  logic                 clk40,
    input  logic                 PRBS_reset,
    input  logic [`LT_CCB_W-1:0] ccb_i,
    input  logic                 inject_i,
    input  lane_vec_t            tx_done_i,
    input  lane_vec_t            rx_done_i,
    input  lane_vec_t            prbs_err_i,
    output lane_vec_t            tx_reset_o,
    output lane_vec_t            rx_reset_o,
    output logic                 inject_o,
    output lane_vec_t            err_latched_o,
    output led_t                 led_o
);

    // Decoded CCB pulses
    ccb_dec_t  ccb_dec;
    // Registered lane flags
    lane_vec_t live_err;
    logic      err_clear;

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    ccb_rx u_ccb_rx (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_i      (ccb_i),
        .dec_o      (ccb_dec)
    );

    lane_monitor u_lane_monitor (
        .clk40         (clk40),
        .PRBS_reset    (PRBS_reset),
        .prbs_err_i    (prbs_err_i),
        .err_clear_i   (err_clear),
        .live_err_o    (live_err),
        .latched_err_o (err_latched_o)
    );

    // Sequencer also composes the LED bank
    boot_fsm u_boot_fsm (
        .clk40         (clk40),
        .PRBS_reset    (PRBS_reset),
        .dec_i         (ccb_dec),
        .inject_i      (inject_i),
        .tx_done_i     (tx_done_i),
        .rx_done_i     (rx_done_i),
        .live_err_i    (live_err),
        .latched_err_i (err_latched_o),
        .tx_reset_o    (tx_reset_o),
        .rx_reset_o    (rx_reset_o),
        .err_clear_o   (err_clear),
        .inject_o      (inject_o),
        .led_o         (led_o)
    );

endmodule

/* sim/link_test_asserts.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module link_test_asserts
    import boot_pkg::*;
(
    input logic      clk40,
    input logic      PRBS_reset,
    input lane_vec_t tx_reset_i,
    input lane_vec_t rx_reset_i,
    input logic      inject_i,
    input led_t      led_i
);

    // Set on any assertion failure, polled by the testbench
    logic fail_seen = 1'b0;

    ////////////////////////////////////////
    // Sequencer output properties
    ////////////////////////////////////////

    // Force-error strobe is a single clk40 pulse
    a_inject_pulse: assert property (
        @(posedge clk40) disable iff (PRBS_reset) inject_i |=> !inject_i
    ) else begin
        $error("inject_o held high for two cycles");
        fail_seen = 1'b1;
    end

    // Receivers stay in reset while any transmitter is in reset
    a_rx_after_tx: assert property (
        @(posedge clk40) disable iff (PRBS_reset) (|tx_reset_i) |-> (&rx_reset_i)
    ) else begin
        $error("rx reset released while a tx reset is high");
        fail_seen = 1'b1;
    end

    // Upper nibble only ever shows a legal phase code
    a_led_code: assert property (
        @(posedge clk40) disable iff (PRBS_reset)
        led_i[7:4] inside {4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b0101,
                           4'b0110, 4'b1000, 4'b0111, 4'b1111}
    ) else begin
        $error("LED phase nibble %b is not a phase code", led_i[7:4]);
        fail_seen = 1'b1;
    end

endmodule

// Attached to every boot sequencer instance
bind boot_fsm link_test_asserts u_link_test_asserts (
    .clk40      (clk40),
    .PRBS_reset (PRBS_reset),
    .tx_reset_i (tx_reset_o),
    .rx_reset_i (rx_reset_o),
    .inject_i   (inject_o),
    .led_i      (led_o)
);

/* sim/tb_link_test.sv */
`timescale 1ns/1ps
`include "link_test_defines.svh"

module tb_link_test
    import ccb_pkg::*;
    import boot_pkg::*;
();

    // Two boots of about 300 cycles plus the test steps and a wide margin
    localparam int max_cycles = 4000;
    localparam lane_vec_t all_lanes = '1;

    logic                 clk40;
    logic                 PRBS_reset;
    logic [`LT_CCB_W-1:0] ccb_i;
    logic                 inject_i;
    lane_vec_t            tx_done_i;
    lane_vec_t            rx_done_i;
    lane_vec_t            prbs_err_i;
    lane_vec_t            tx_reset_o;
    lane_vec_t            rx_reset_o;
    logic                 inject_o;
    lane_vec_t            err_latched_o;
    led_t                 led_o;

    integer      seed        = 32'hbe30_ef09;
    int          cycles      = 0;
    int          errors      = 0;
    // Phase as followed from the LED nibble
    boot_phase_t cur_phase   = RESET;
    lane_vec_t   exp_latched = '0;
    logic        exp_inject  = 1'b0;

    link_test_top u_link_test_top (
        .clk40         (clk40),
        .PRBS_reset    (PRBS_reset),
        .ccb_i         (ccb_i),
        .inject_i      (inject_i),
        .tx_done_i     (tx_done_i),
        .rx_done_i     (rx_done_i),
        .prbs_err_i    (prbs_err_i),
        .tx_reset_o    (tx_reset_o),
        .rx_reset_o    (rx_reset_o),
        .inject_o      (inject_o),
        .err_latched_o (err_latched_o),
        .led_o         (led_o)
    );

    initial begin
        clk40 = 1'b0;
        forever #20 clk40 = ~clk40;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        if (exp !== act) begin
            report_failure($sformatf("MISMATCH at %0t: %s expected %0h, actual %0h",
                                     $time, name, exp, act));
        end
    endtask

    // Front-panel legend in boot order
    // Inject done and clear swap their natural order on the panel
    function automatic logic [3:0] phase_nibble(input boot_phase_t ph);
        case (ph)
            RESET:             return 4'b0001;
            EN_TX:             return 4'b0010;
            EN_TX_DONE:        return 4'b0011;
            EN_RX:             return 4'b0100;
            EN_RX_DONE:        return 4'b0101;
            PRBS_INJECT:       return 4'b0110;
            PRBS_INJECT_DONE:  return 4'b1000;
            PRBS_INJECT_CLEAR: return 4'b0111;
            EN_PRBS_CK:        return 4'b1111;
            default:           return 4'bxxxx;
        endcase
    endfunction

    // Expected LED bank with the phase code high and latched lanes 4 to 7 low in check
    // No lane errors are driven while booting, so other phases show zero
    function automatic led_t exp_led(input boot_phase_t ph, input lane_vec_t lat);
        led_t led;
        led[7:4] = phase_nibble(ph);
        if (ph == EN_PRBS_CK) begin
            led[3:0] = lat[`LT_LANES-1:`LT_DISP_LO];
        end else begin
            led[3:0] = 4'b0000;
        end
        return led;
    endfunction

    // CCB word as seen on the active-low pins
    function automatic logic [`LT_CCB_W-1:0] ccb_word(input ccb_cmd_t cmd,
                                                      input logic strobe);
        logic [`LT_CCB_W-1:0] word;
        word = '0;
        word[`LT_CMD_LSB +: `LT_CMD_W] = cmd;
        word[`LT_STROBE_BIT] = strobe;
        return ~word;
    endfunction

    // One command word for one cycle and then idle again
    task automatic send_ccb(input ccb_cmd_t cmd, input logic strobe);
        ccb_i = ccb_word(cmd, strobe);
        @(negedge clk40);
        ccb_i = '1;
    endtask

    // Wait for the LED nibble to move on, then expect the given phase
    task automatic wait_phase(input boot_phase_t ph);
        while (led_o[7:4] == phase_nibble(cur_phase)) begin
            @(negedge clk40);
        end
        check_val("led_o", exp_led(ph, '0), led_o);
        cur_phase = ph;
    endtask

    // Full boot from RESET to check with random done-flag delays
    task automatic run_boot();
        int start;
        int delay;
        start       = cycles;
        cur_phase   = RESET;
        exp_latched = '0;
        tx_done_i   = '0;
        rx_done_i   = '0;
        check_val("led_o", exp_led(RESET, '0), led_o);
        wait_phase(EN_TX);
        wait_phase(EN_TX_DONE);
        delay = 2 + ($random(seed) & 15);
        repeat (delay) begin
            check_val("rx_reset_o", all_lanes, rx_reset_o);
            @(negedge clk40);
        end
        tx_done_i = all_lanes;
        wait_phase(EN_RX);
        check_val("tx_reset_o", 0, tx_reset_o);
        check_val("rx_reset_o", 0, rx_reset_o);
        wait_phase(EN_RX_DONE);
        delay = 2 + ($random(seed) & 15);
        repeat (delay) @(negedge clk40);
        rx_done_i = all_lanes;
        wait_phase(PRBS_INJECT);
        wait_phase(PRBS_INJECT_DONE);
        wait_phase(PRBS_INJECT_CLEAR);
        wait_phase(EN_PRBS_CK);
        if (cycles - start < `LT_T_CLEAR) begin
            report_failure($sformatf("boot finished after only %0d cycles",
                                     cycles - start));
        end
    endtask

    // Single-cycle error on one lane that latches two clocks later
    task automatic hit_lane(input int lane);
        prbs_err_i = all_lanes & (1 << lane);
        @(negedge clk40);
        prbs_err_i = '0;
        exp_latched[lane] = 1'b1;
        repeat (4) @(negedge clk40);
    endtask

    ////////////////////////////////////////
    // Compare and timeout
    ////////////////////////////////////////

    // Outputs are sampled a quarter period after the rising edge
    always @(posedge clk40) begin
        #10;
        if (u_link_test_top.u_boot_fsm.u_link_test_asserts.fail_seen) begin
            report_failure("a bound assertion on the boot sequencer failed");
        end
        if (cur_phase == EN_PRBS_CK) begin
            check_val("led_o", exp_led(cur_phase, exp_latched), led_o);
            check_val("err_latched_o", exp_latched, err_latched_o);
            check_val("inject_o", exp_inject, inject_o);
            check_val("tx_reset_o", 0, tx_reset_o);
            check_val("rx_reset_o", 0, rx_reset_o);
        end
    end

    always @(posedge clk40) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            report_failure($sformatf("timeout, run did not end within %0d cycles",
                                     max_cycles));
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        PRBS_reset = 1'b1;
        ccb_i      = '1;
        inject_i   = 1'b0;
        tx_done_i  = '0;
        rx_done_i  = '0;
        prbs_err_i = '0;
        repeat (8) @(negedge clk40);
        // Reset state
        check_val("tx_reset_o", all_lanes, tx_reset_o);
        check_val("rx_reset_o", all_lanes, rx_reset_o);
        check_val("inject_o", 0, inject_o);
        check_val("led_o", 8'b0001_0000, led_o);
        PRBS_reset = 1'b0;
        run_boot();

        // One lane anywhere, then one that shows on the LEDs
        hit_lane($random(seed) & 7);
        hit_lane(`LT_DISP_LO + ($random(seed) & 3));

        // Bx reset without strobe leaves the latch alone
        send_ccb(`LT_CMD_BXRESET, 1'b0);
        repeat (4) @(negedge clk40);
        // With strobe the latch empties three clocks after the word
        send_ccb(`LT_CMD_BXRESET, 1'b1);
        @(negedge clk40);
        exp_latched = '0;
        repeat (3) @(negedge clk40);

        // Bx0 gives one inject pulse three clocks later
        send_ccb(`LT_CMD_BX0, 1'b1);
        @(negedge clk40);
        exp_inject = 1'b1;
        @(negedge clk40);
        exp_inject = 1'b0;
        repeat (3) @(negedge clk40);

        // Inject button edge gives one pulse two clocks later
        inject_i = 1'b1;
        @(negedge clk40);
        exp_inject = 1'b1;
        @(negedge clk40);
        exp_inject = 1'b0;
        // Held level stays quiet
        repeat (8) @(negedge clk40);
        inject_i = 1'b0;
        repeat (4) @(negedge clk40);

        // Resync back to RESET, then a second boot
        cur_phase = RESET;
        send_ccb(`LT_CMD_RESYNC, 1'b1);
        while (led_o[7:4] == phase_nibble(EN_PRBS_CK)) begin
            @(negedge clk40);
        end
        check_val("led_o", exp_led(RESET, '0), led_o);
        check_val("tx_reset_o", all_lanes, tx_reset_o);
        check_val("rx_reset_o", all_lanes, rx_reset_o);
        run_boot();
        repeat (8) @(negedge clk40);

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+design
design/ccb_pkg.sv
design/boot_pkg.sv
design/ccb_rx.sv
design/lane_monitor.sv
design/boot_fsm.sv
design/link_test_top.sv
sim/link_test_asserts.sv
sim/tb_link_test.sv
